// ==== ibuf_settings.svh ====
////////////////////
// instruction buffer sizing: warp count, queue depth and field widths
////////////////////

`ifndef IBUF_SETTINGS_SVH
`define IBUF_SETTINGS_SVH

// number of warps sharing the buffer stage
`define IBUF_NUM_WARPS 4

// warp id width, must cover IBUF_NUM_WARPS
`define IBUF_WID_W 2

// queue entries held per warp, counting the output register
`define IBUF_DEPTH 2

// register index width for rd, rs1 and rs2
`define IBUF_REG_W 5

// width of the decode stall counter
`define IBUF_PERF_W 16

`endif

// ==== ibuf_pkg.sv ====
////////////////////
// instruction buffer types: unit and micro-op encodings, instruction words
////////////////////

`default_nettype none

`include "ibuf_settings.svh"

package ibuf_pkg;

    // execution unit that will consume the instruction
    typedef enum logic [1:0] {
        EX_ALU    = 2'd0,
        EX_LSU    = 2'd1,
        EX_SFU    = 2'd2,
        EX_BRANCH = 2'd3
    } ex_type_e;

    // position of a micro-op within its parent instruction
    typedef enum logic [1:0] {
        UOP_SINGLE  = 2'd0,
        UOP_PAIR_LO = 2'd1,
        UOP_PAIR_HI = 2'd2
    } uop_e;

    typedef struct packed {
        logic [15:0]            uuid;
        logic [31:0]            pc;
        ex_type_e               ex_type;
        logic [3:0]             op_type;
        logic                   paired;
        logic                   wb;
        logic [`IBUF_REG_W-1:0] rd;
        logic [`IBUF_REG_W-1:0] rs1;
        logic [`IBUF_REG_W-1:0] rs2;
    } instr_t;

    // word handed to the scheduler
    typedef struct packed {
        instr_t instr;
        uop_e   uop;
    } uop_t;

endpackage

`default_nettype wire

// ==== decode_if.sv ====
////////////////////
// decode to buffer link: instruction stream plus per-warp pop pulses
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ibuf_settings.svh"

interface decode_if;

    logic                      valid;
    logic                      ready;
    logic [`IBUF_WID_W-1:0]    wid;
    ibuf_pkg::instr_t          data;
    // one pulse per instruction leaving a warp queue, used by fetch for credits
    logic [`IBUF_NUM_WARPS-1:0] pop;

    modport master (output valid, output wid, output data, input ready, input pop);

    modport slave (input valid, input wid, input data, output ready, output pop);

endinterface

`default_nettype wire

// ==== ibuffer_if.sv ====
////////////////////
// one warp's micro-op stream toward the scheduler
////////////////////

`timescale 1ns/100ps
`default_nettype none

interface ibuffer_if;

    logic             valid;
    logic             ready;
    ibuf_pkg::uop_t   data;
    // marks the final micro-op of an instruction
    logic             last;

    modport master (output valid, output data, output last, input ready);

    modport slave (input valid, input data, input last, output ready);

endinterface

`default_nettype wire

// ==== elastic_buffer.sv ====
////////////////////
// elastic buffer: circular FIFO whose head sits in an output register
////////////////////

`timescale 1ns/100ps
`default_nettype none

module elastic_buffer #(
    parameter int DATAW = 8,
    parameter int DEPTH = 2
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              valid_in,
    input  wire [DATAW-1:0]  data_in,
    output logic             ready_in,
    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  wire              ready_out
);

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);

    // storage keeps every held entry, the head is also mirrored in data_q
    logic [DATAW-1:0]  mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  count_nxt;
    logic              valid_q;
    logic [DATAW-1:0]  data_q;
    logic              push;
    logic              pop;

    function automatic logic [ADDR_W-1:0] ptr_inc(input logic [ADDR_W-1:0] ptr);
        if (ptr == ADDR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // space is judged on occupancy alone, so ready_in never waits on ready_out
    assign ready_in  = (count < CNT_W'(DEPTH));
    assign push      = valid_in && ready_in;
    assign pop       = valid_q && ready_out;
    assign valid_out = valid_q;
    assign data_out  = data_q;

    always_comb begin
        count_nxt = count;
        if (push && !pop) begin
            count_nxt = count + 1'b1;
        end else if (pop && !push) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            valid_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count   <= count_nxt;
            valid_q <= (count_nxt != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
        // the next head comes from storage, or straight from the input when none is left
        if (pop && count > CNT_W'(1)) begin
            data_q <= mem[ptr_inc(rd_ptr)];
        end else if ((pop || count == '0) && push) begin
            data_q <= data_in;
        end
    end

endmodule

`default_nettype wire

// ==== uop_sequencer.sv ====
////////////////////
// micro-op sequencer: splits paired instructions into two micro-ops
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ibuf_settings.svh"

module uop_sequencer (
    input  wire        clk,
    input  wire        reset,
    ibuffer_if.slave   input_if,
    ibuffer_if.master  output_if
);

    typedef enum logic {
        ST_FIRST  = 1'b0,
        ST_SECOND = 1'b1
    } state_e;

    state_e           state;
    ibuf_pkg::instr_t in_instr;
    ibuf_pkg::instr_t hi_instr;
    ibuf_pkg::uop_t   out_uop;
    logic             out_last;
    logic             out_fire;

    assign in_instr = input_if.data.instr;

    // the high half works on the next register of each operand
    always_comb begin
        hi_instr      = in_instr;
        hi_instr.uuid = in_instr.uuid + 16'd1;
        hi_instr.rd   = in_instr.rd + `IBUF_REG_W'(1);
        hi_instr.rs1  = in_instr.rs1 + `IBUF_REG_W'(1);
        hi_instr.rs2  = in_instr.rs2 + `IBUF_REG_W'(1);
    end

    always_comb begin
        if (!in_instr.paired) begin
            out_uop.instr = in_instr;
            out_uop.uop   = ibuf_pkg::UOP_SINGLE;
            out_last      = 1'b1;
        end else if (state == ST_FIRST) begin
            out_uop.instr = in_instr;
            out_uop.uop   = ibuf_pkg::UOP_PAIR_LO;
            out_last      = 1'b0;
        end else begin
            out_uop.instr = hi_instr;
            out_uop.uop   = ibuf_pkg::UOP_PAIR_HI;
            out_last      = 1'b1;
        end
    end

    assign output_if.valid = input_if.valid;
    assign output_if.data  = out_uop;
    assign output_if.last  = out_last;

    // the queue entry is released only together with the final micro-op
    assign input_if.ready  = output_if.ready && out_last;

    assign out_fire = output_if.valid && output_if.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FIRST;
        end else if (out_fire && in_instr.paired) begin
            state <= (state == ST_FIRST) ? ST_SECOND : ST_FIRST;
        end
    end

endmodule

`default_nettype wire

// ==== instr_buffer.sv ====
////////////////////
// instruction buffer: per-warp queues and sequencers behind one decode port
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ibuf_settings.svh"

module instr_buffer (
    input  wire                    clk,
    input  wire                    reset,
    decode_if.slave                decode_if,
    ibuffer_if.master              ibuffer_if [`IBUF_NUM_WARPS],
    output logic [`IBUF_PERF_W-1:0] stall_count
);

    localparam int INSTR_W = $bits(ibuf_pkg::instr_t);

    wire  [`IBUF_NUM_WARPS-1:0] queue_ready;
    wire  [`IBUF_NUM_WARPS-1:0] queue_pop;
    logic                       dec_stall;

    // decode sees only the space left in the queue it is addressing
    assign decode_if.ready = queue_ready[decode_if.wid];
    assign decode_if.pop   = queue_pop;

    for (genvar w = 0; w < `IBUF_NUM_WARPS; w++) begin : g_warp
        ibuffer_if        seq_if ();
        ibuf_pkg::instr_t q_data;

        elastic_buffer #(
            .DATAW (INSTR_W),
            .DEPTH (`IBUF_DEPTH)
        ) queue (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (decode_if.valid && (decode_if.wid == `IBUF_WID_W'(w))),
            .data_in   (decode_if.data),
            .ready_in  (queue_ready[w]),
            .valid_out (seq_if.valid),
            .data_out  (q_data),
            .ready_out (seq_if.ready)
        );

        // the sequencer assigns the real micro-op tag, last has no meaning here
        assign seq_if.data = '{instr: q_data, uop: ibuf_pkg::UOP_SINGLE};
        assign seq_if.last = 1'b1;

        assign queue_pop[w] = seq_if.valid && seq_if.ready;

        uop_sequencer seq (
            .clk       (clk),
            .reset     (reset),
            .input_if  (seq_if),
            .output_if (ibuffer_if[w])
        );
    end

    // cycles where decode has an instruction but its warp queue is full
    assign dec_stall = decode_if.valid && !decode_if.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_count <= '0;
        end else begin
            stall_count <= stall_count + `IBUF_PERF_W'(dec_stall);
        end
    end

endmodule

`default_nettype wire

// ==== ibuf_top.sv ====
////////////////////
// instruction buffer top: plain ports wrapped onto the internal interfaces
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ibuf_settings.svh"

module ibuf_top (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire                                        dec_valid,
    input  wire [`IBUF_WID_W-1:0]                      dec_wid,
    input  wire ibuf_pkg::instr_t                      dec_data,
    output logic                                       dec_ready,
    output logic [`IBUF_NUM_WARPS-1:0]                 dec_pop,
    output logic [`IBUF_NUM_WARPS-1:0]                 out_valid,
    output ibuf_pkg::uop_t [`IBUF_NUM_WARPS-1:0]       out_data,
    output logic [`IBUF_NUM_WARPS-1:0]                 out_last,
    input  wire  [`IBUF_NUM_WARPS-1:0]                 out_ready,
    output logic [`IBUF_PERF_W-1:0]                    stall_count
);

    decode_if  dec_if ();
    ibuffer_if out_if [`IBUF_NUM_WARPS] ();

    assign dec_if.valid = dec_valid;
    assign dec_if.wid   = dec_wid;
    assign dec_if.data  = dec_data;
    assign dec_ready    = dec_if.ready;
    assign dec_pop      = dec_if.pop;

    // one scheduler-facing stream per warp
    for (genvar w = 0; w < `IBUF_NUM_WARPS; w++) begin : g_out
        assign out_valid[w]    = out_if[w].valid;
        assign out_data[w]     = out_if[w].data;
        assign out_last[w]     = out_if[w].last;
        assign out_if[w].ready = out_ready[w];
    end

    instr_buffer ibuf (
        .clk         (clk),
        .reset       (reset),
        .decode_if   (dec_if),
        .ibuffer_if  (out_if),
        .stall_count (stall_count)
    );

endmodule

`default_nettype wire

// ==== tb_ibuf_assertions.sv ====
////////////////////
// protocol assertions for the instruction buffer that bind into instr_buffer
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ibuf_settings.svh"

module ibuf_assertions (
    input wire        clk,
    input wire        reset,
    decode_if.slave   dec,
    ibuffer_if.master out_if [`IBUF_NUM_WARPS]
);

    for (genvar w = 0; w < `IBUF_NUM_WARPS; w++) begin : g_warp
        // a stalled micro-op must wait unchanged for the scheduler
        a_hold_stable: assert property (@(posedge clk) disable iff (reset)
            out_if[w].valid && !out_if[w].ready |=> out_if[w].valid && $stable(out_if[w].data))
            else $error("warp %0d micro-op changed while stalled", w);

        // once an entry is released the next instruction starts from its first micro-op
        a_pop_restarts: assert property (@(posedge clk) disable iff (reset)
            dec.pop[w] |=> !out_if[w].valid || out_if[w].data.uop != ibuf_pkg::UOP_PAIR_HI)
            else $error("warp %0d began an instruction with its high half", w);

        a_reset_idle: assert property (@(posedge clk)
            reset |=> !out_if[w].valid && !dec.pop[w])
            else $error("warp %0d output active right after reset", w);
    end

endmodule

bind instr_buffer ibuf_assertions asrt0 (
    .clk    (clk),
    .reset  (reset),
    .dec    (decode_if),
    .out_if (ibuffer_if)
);

`default_nettype wire

// ==== tb_ibuf.sv ====
////////////////////
// testbench for the instruction buffer stage with random traffic checked against a reference model
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ibuf_settings.svh"

module tb_ibuf;

    localparam int NUM_INSTR  = 400;
    localparam int NW         = `IBUF_NUM_WARPS;
    localparam int MAX_CYCLES = NUM_INSTR * 2 * 8 + 1000;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    dec_valid;
    logic [`IBUF_WID_W-1:0]  dec_wid;
    ibuf_pkg::instr_t        dec_data;
    logic                    dec_ready;
    logic [NW-1:0]           dec_pop;
    logic [NW-1:0]           out_valid;
    ibuf_pkg::uop_t [NW-1:0] out_data;
    logic [NW-1:0]           out_last;
    logic [NW-1:0]           out_ready;
    logic [`IBUF_PERF_W-1:0] stall_count;

    // expected micro-ops per warp, in acceptance order
    ibuf_pkg::uop_t exp_q [NW][$];
    int accepted [NW];
    int pops [NW];
    int hold_low [NW];
    int total_accepted;
    int stall_cycles;
    int uops_seen;
    int checks;
    int errors;
    int cycles;
    bit reset_seen;
    bit draining;

    ibuf_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .dec_valid   (dec_valid),
        .dec_wid     (dec_wid),
        .dec_data    (dec_data),
        .dec_ready   (dec_ready),
        .dec_pop     (dec_pop),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_ready   (out_ready),
        .stall_count (stall_count)
    );

    always #10 clk = ~clk;

    // a paired instruction becomes a low half and a high half on the next registers
    function automatic int expand(input ibuf_pkg::instr_t ins, output ibuf_pkg::uop_t uops [2]);
        uops[0].instr = ins;
        uops[1].instr = ins;
        if (!ins.paired) begin
            uops[0].uop = ibuf_pkg::UOP_SINGLE;
            return 1;
        end
        uops[0].uop        = ibuf_pkg::UOP_PAIR_LO;
        uops[1].uop        = ibuf_pkg::UOP_PAIR_HI;
        uops[1].instr.uuid = ins.uuid + 16'd1;
        uops[1].instr.rd   = ins.rd + 1'b1;
        uops[1].instr.rs1  = ins.rs1 + 1'b1;
        uops[1].instr.rs2  = ins.rs2 + 1'b1;
        return 2;
    endfunction

    function automatic ibuf_pkg::instr_t make_instr(input int idx);
        ibuf_pkg::instr_t ins;
        ins.uuid    = 16'($urandom);
        ins.pc      = 32'h0000_1000 + 32'(idx * 4);
        ins.ex_type = ibuf_pkg::ex_type_e'($urandom_range(0, 3));
        ins.op_type = 4'($urandom);
        ins.paired  = ($urandom_range(0, 2) == 0);
        ins.wb      = 1'($urandom);
        ins.rd      = `IBUF_REG_W'($urandom);
        ins.rs1     = `IBUF_REG_W'($urandom);
        ins.rs2     = `IBUF_REG_W'($urandom);
        return ins;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int w = 0; w < NW; w++) begin
            n += exp_q[w].size();
        end
        return n;
    endfunction

    task automatic drive_ready();
        for (int w = 0; w < NW; w++) begin
            if (draining) begin
                out_ready[w] = 1'b1;
            end else if (hold_low[w] > 0) begin
                hold_low[w]--;
                out_ready[w] = 1'b0;
            end else if ($urandom_range(0, 63) == 0) begin
                // a long stall lets this warp's queue fill while the others keep going
                hold_low[w]  = $urandom_range(8, 24);
                out_ready[w] = 1'b0;
            end else begin
                out_ready[w] = ($urandom_range(0, 3) != 0);
            end
        end
    endtask

    task automatic check_reset_state(input string phase);
        checks++;
        if (out_valid !== '0 || dec_pop !== '0 || stall_count !== '0) begin
            errors++;
            $display("[ERROR] reset state %s: expected 0/0/0, actual %h/%h/%h",
                     phase, out_valid, dec_pop, stall_count);
        end
    endtask

    task automatic compare_output(input int w);
        ibuf_pkg::uop_t exp_uop;
        uops_seen++;
        if (exp_q[w].size() == 0) begin
            errors++;
            $display("warp %0d delivered a micro-op that no accepted instruction explains", w);
            return;
        end
        exp_uop = exp_q[w].pop_front();
        checks += 2;
        if (out_data[w] !== exp_uop) begin
            errors++;
            $display("[ERROR] micro-op warp %0d: expected %h, actual %h", w, exp_uop, out_data[w]);
        end
        if (out_last[w] !== (exp_uop.uop != ibuf_pkg::UOP_PAIR_LO)) begin
            errors++;
            $display("[ERROR] last flag warp %0d: expected %0b, actual %0b",
                     w, exp_uop.uop != ibuf_pkg::UOP_PAIR_LO, out_last[w]);
        end
    endtask

    task automatic report_and_finish();
        $display("instructions %0d, micro-ops %0d, stall cycles %0d, checks %0d, errors %0d",
                 total_accepted, uops_seen, stall_cycles, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // everything is sampled mid-cycle once inputs and outputs have settled
    always @(negedge clk) begin
        ibuf_pkg::uop_t new_uops [2];
        int n;
        bit exp_ready;
        if (reset) begin
            check_reset_state("during reset");
            reset_seen = 1'b1;
        end else begin
            if (reset_seen) begin
                check_reset_state("after reset");
                reset_seen = 1'b0;
            end
            if (dec_valid) begin
                // a queue holds what was accepted and not yet handed on
                exp_ready = (accepted[dec_wid] - pops[dec_wid]) < `IBUF_DEPTH;
                checks++;
                if (dec_ready !== exp_ready) begin
                    errors++;
                    $display("[ERROR] dec_ready warp %0d: expected %0b, actual %0b",
                             dec_wid, exp_ready, dec_ready);
                end
                if (!dec_ready) begin
                    stall_cycles++;
                end else begin
                    n = expand(dec_data, new_uops);
                    for (int i = 0; i < n; i++) begin
                        exp_q[dec_wid].push_back(new_uops[i]);
                    end
                    accepted[dec_wid]++;
                    total_accepted++;
                end
            end
            for (int w = 0; w < NW; w++) begin
                if (dec_pop[w]) begin
                    pops[w]++;
                end
                if (out_valid[w] && out_ready[w]) begin
                    compare_output(w);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            report_and_finish();
        end
    end

    initial begin
        int sent;
        bit took;
        sent = 0;
        void'($urandom(32'h5867_ccb0));
        reset     = 1'b1;
        dec_valid = 1'b0;
        dec_wid   = '0;
        dec_data  = '0;
        out_ready = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        while (sent < NUM_INSTR) begin
            @(negedge clk);
            took = dec_valid && dec_ready;
            @(posedge clk);
            #1;
            drive_ready();
            if (took) begin
                sent++;
                dec_valid = 1'b0;
            end
            // a held instruction keeps its warp and data until accepted
            if (!dec_valid && sent < NUM_INSTR && $urandom_range(0, 3) != 0) begin
                dec_valid = 1'b1;
                dec_wid   = `IBUF_WID_W'($urandom_range(0, NW - 1));
                dec_data  = make_instr(sent);
            end
        end
        draining = 1'b1;
        drive_ready();
        while (pending() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        for (int w = 0; w < NW; w++) begin
            checks++;
            if (pops[w] != accepted[w]) begin
                errors++;
                $display("[ERROR] pop count warp %0d: expected %0d, actual %0d",
                         w, accepted[w], pops[w]);
            end
        end
        checks++;
        if (stall_count !== `IBUF_PERF_W'(stall_cycles)) begin
            errors++;
            $display("[ERROR] stall count: expected %0d, actual %0d", stall_cycles, stall_count);
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
ibuf_pkg.sv
decode_if.sv
ibuffer_if.sv
elastic_buffer.sv
uop_sequencer.sv
instr_buffer.sv
ibuf_top.sv
tb_ibuf_assertions.sv
tb_ibuf.sv

// ==== Bender.yml ====
package:
  name: ibuf_stage

export_include_dirs:
  - .

sources:
  - files:
      - ibuf_pkg.sv
      - decode_if.sv
      - ibuffer_if.sv
      - elastic_buffer.sv
      - uop_sequencer.sv
      - instr_buffer.sv
      - ibuf_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ibuf_assertions.sv
      - tb_ibuf.sv
